// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// Sizes
	localparam int TAG_BITS = 4;
	localparam int REG_BITS = 5;
	localparam int REG_COUNT = 32;
	localparam int RAM_WORDS = 256;
	localparam int RAM_ADDR_BITS = $clog2(RAM_WORDS);

	// Cycles from first request to ready
	localparam int RAM_WAIT = 2;
	localparam int RAM_WAIT_BITS = $clog2(RAM_WAIT + 1);
	localparam logic [RAM_WAIT_BITS-1:0] RAM_WAIT_LAST = RAM_WAIT_BITS'(RAM_WAIT - 1);

	// Memory stage FSM encoding
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_RMW_READ = 2'd1;
	localparam logic [1:0] ST_RMW_REQUEST = 2'd2;
	localparam logic [1:0] ST_RMW_WAIT = 2'd3;

	typedef enum logic [2:0] {
		MEM_BYTE = 3'd1,
		MEM_HALF = 3'd2,
		MEM_WORD = 3'd4
	} mem_width_e;

	// One bus word, seen as byte lanes or half lanes
	typedef union packed {
		logic [3:0][7:0] bytes;
		logic [1:0][15:0] halves;
	} mem_word_u;

	typedef struct packed {
		logic [TAG_BITS-1:0] tag;
		logic [REG_BITS-1:0] inst_rd;
		logic [31:0] rd;
		logic [31:0] pc_next;
		logic mem_read;
		logic mem_write;
		mem_width_e width;
		logic is_signed;
		logic [31:0] address;
	} mem_req_t;

	typedef struct packed {
		logic [TAG_BITS-1:0] tag;
		logic [REG_BITS-1:0] inst_rd;
		logic [31:0] rd;
		logic [31:0] pc_next;
	} mem_result_t;

	typedef struct packed {
		logic rw;
		logic request;
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic ready;
		logic [31:0] rdata;
	} bus_rsp_t;

endpackage

`default_nettype wire

// ==== mem_lane_align.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_lane_align
	import cpu_pkg::*;
(
	input wire mem_word_u i_word,
	input wire [1:0] i_byte_index,
	input wire mem_width_e i_width,
	input wire i_signed,
	input wire [31:0] i_store_data,
	output logic [31:0] o_load_value,
	output logic [31:0] o_merged_word
);

	logic [7:0] load_byte;
	logic [15:0] load_half;
	mem_word_u merged;

	// Halves are only addressed at offsets 0 and 2
	assign load_byte = i_word.bytes[i_byte_index];
	assign load_half = i_word.halves[i_byte_index[1]];

	always_comb begin
		case (i_width)
			MEM_BYTE: begin
				o_load_value = {{24{i_signed & load_byte[7]}}, load_byte};
			end
			MEM_HALF: begin
				o_load_value = {{16{i_signed & load_half[15]}}, load_half};
			end
			default: begin
				o_load_value = i_word;
			end
		endcase
	end

	// Drop the new lane into the word read back from the bus
	always_comb begin
		merged = i_word;
		case (i_width)
			MEM_BYTE: begin
				merged.bytes[i_byte_index] = i_store_data[7:0];
			end
			MEM_HALF: begin
				if (i_byte_index[0]) begin
					// Misaligned half
					merged = '0;
				end else begin
					merged.halves[i_byte_index[1]] = i_store_data[15:0];
				end
			end
			default: begin
				merged = i_store_data;
			end
		endcase
	end

	assign o_merged_word = merged;

endmodule

`default_nettype wire

// ==== cpu_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_memory
	import cpu_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	input wire mem_req_t i_req,

	output bus_req_t o_bus,
	input wire bus_rsp_t i_bus,

	output mem_result_t o_result,
	output logic o_stall
);

	logic [1:0] state;
	logic bus_rw;
	logic bus_request;
	logic [31:0] bus_wdata;
	logic new_req;
	logic is_access;
	logic word_store;
	logic done;
	logic [31:0] load_value;
	logic [31:0] merged_word;

	assign new_req = (i_req.tag != o_result.tag);
	assign is_access = i_req.mem_read | i_req.mem_write;
	assign word_store = i_req.mem_write && (i_req.width == MEM_WORD);

	// Hold upstream until the access has finished
	assign o_stall = new_req && is_access;

	assign o_bus = '{
		rw: bus_rw,
		request: bus_request,
		address: {i_req.address[31:2], 2'b00},
		wdata: bus_wdata
	};

	mem_lane_align mem_lane_align_i (
		.i_word(i_bus.rdata),
		.i_byte_index(i_req.address[1:0]),
		.i_width(i_req.width),
		.i_signed(i_req.is_signed),
		.i_store_data(i_req.rd),
		.o_load_value(load_value),
		.o_merged_word(merged_word)
	);

	always_comb begin
		done = 1'b0;
		case (state)
			ST_IDLE: begin
				if (new_req) begin
					if (!is_access) begin
						done = 1'b1;
					end else if (i_req.mem_read || word_store) begin
						done = i_bus.ready;
					end
				end
			end
			ST_RMW_WAIT: begin
				done = i_bus.ready;
			end
			default: begin
				done = 1'b0;
			end
		endcase
	end

	// Bus side
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			bus_rw <= 1'b0;
			bus_request <= 1'b0;
			bus_wdata <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (new_req && is_access) begin
						bus_request <= 1'b1;
						if (i_req.mem_read) begin
							if (i_bus.ready) begin
								bus_request <= 1'b0;
							end
						end else if (word_store) begin
							bus_rw <= 1'b1;
							bus_wdata <= i_req.rd;
							if (i_bus.ready) begin
								bus_rw <= 1'b0;
								bus_request <= 1'b0;
							end
						end else begin
							// Narrow store reads the old word first
							bus_rw <= 1'b0;
							state <= ST_RMW_READ;
						end
					end
				end
				ST_RMW_READ: begin
					if (i_bus.ready) begin
						bus_request <= 1'b0;
						bus_rw <= 1'b1;
						bus_wdata <= merged_word;
						state <= ST_RMW_REQUEST;
					end
				end
				ST_RMW_REQUEST: begin
					// Request was low for one cycle, raise it for the write
					bus_request <= 1'b1;
					state <= ST_RMW_WAIT;
				end
				ST_RMW_WAIT: begin
					if (i_bus.ready) begin
						bus_request <= 1'b0;
						bus_rw <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Result register
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_result <= '0;
		end else if (done) begin
			o_result.tag <= i_req.tag;
			o_result.inst_rd <= i_req.inst_rd;
			o_result.pc_next <= i_req.pc_next;
			if (i_req.mem_read) begin
				o_result.rd <= load_value;
			end else if (!i_req.mem_write) begin
				o_result.rd <= i_req.rd;
			end
		end
	end

endmodule

`default_nettype wire

// ==== bus_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_ram
	import cpu_pkg::*;
(
	input wire i_clock,
	input wire i_reset,
	input wire bus_req_t i_bus,
	output bus_rsp_t o_bus
);

	logic [31:0] mem [RAM_WORDS];
	logic [RAM_WAIT_BITS-1:0] wait_count;
	logic [RAM_ADDR_BITS-1:0] word_index;
	logic ready;
	logic [31:0] rdata;
	logic access;

	initial begin
		for (int i = 0; i < RAM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	// Address wraps at the RAM depth
	assign word_index = i_bus.address[RAM_ADDR_BITS+1:2];

	// Last wait cycle; ignore the request still held during ready
	assign access = i_bus.request && !ready && (wait_count == RAM_WAIT_LAST);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wait_count <= '0;
			ready <= 1'b0;
		end else begin
			ready <= 1'b0;
			if (i_bus.request && !ready) begin
				if (access) begin
					ready <= 1'b1;
					wait_count <= '0;
				end else begin
					wait_count <= wait_count + 1'b1;
				end
			end else begin
				wait_count <= '0;
			end
		end
	end

	// Data path, valid in the ready cycle
	always_ff @(posedge i_clock) begin
		if (access) begin
			if (i_bus.rw) begin
				mem[word_index] <= i_bus.wdata;
				rdata <= i_bus.wdata;
			end else begin
				rdata <= mem[word_index];
			end
		end
	end

	assign o_bus = '{ready: ready, rdata: rdata};

endmodule

`default_nettype wire

// ==== writeback_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module writeback_regfile
	import cpu_pkg::*;
(
	input wire i_clock,
	input wire i_reset,
	input wire mem_result_t i_result,
	input wire [REG_BITS-1:0] i_read_index,
	output logic [31:0] o_read_data
);

	logic [31:0] regs [REG_COUNT];
	logic [TAG_BITS-1:0] last_tag;
	logic result_new;

	// Each finished instruction shows up as a tag change
	assign result_new = (i_result.tag != last_tag);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			last_tag <= '0;
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (result_new) begin
			last_tag <= i_result.tag;
			if (i_result.inst_rd != '0) begin
				regs[i_result.inst_rd] <= i_result.rd;
			end
		end
	end

	// x0 is hardwired
	assign o_read_data = (i_read_index == '0) ? 32'd0 : regs[i_read_index];

endmodule

`default_nettype wire

// ==== mem_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem
	import cpu_pkg::*;
(
	input wire i_clock,
	input wire i_reset,
	input wire mem_req_t i_req,
	output logic o_stall,
	output mem_result_t o_result,
	input wire [REG_BITS-1:0] i_read_index,
	output logic [31:0] o_read_data
);

	wire bus_req_t bus_req;
	wire bus_rsp_t bus_rsp;

	cpu_memory cpu_memory_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req(i_req),
		.o_bus(bus_req),
		.i_bus(bus_rsp),
		.o_result(o_result),
		.o_stall(o_stall)
	);

	bus_ram bus_ram_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus(bus_req),
		.o_bus(bus_rsp)
	);

	// Writeback sees the same registered result as the port
	writeback_regfile writeback_regfile_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_result(o_result),
		.i_read_index(i_read_index),
		.o_read_data(o_read_data)
	);

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_checker
	import cpu_pkg::*;
(
	input wire i_clock,
	input wire i_reset,
	input wire mem_req_t i_req,
	input wire i_stall,
	input wire mem_result_t i_result,
	input wire i_sweep,
	input wire [REG_BITS-1:0] i_read_index,
	input wire [31:0] i_read_data,
	output int o_checked,
	output int o_value_errors,
	output int o_protocol_errors
);

	localparam int ACCESS_BOUND = 3 * RAM_WAIT + 8;

	logic [31:0] mem_model [RAM_WORDS];
	logic [31:0] reg_model [REG_COUNT];
	logic [31:0] last_rd;
	logic [TAG_BITS-1:0] last_req_tag;
	logic pending;
	int wait_cycles;

	initial begin
		for (int i = 0; i < RAM_WORDS; i++) begin
			mem_model[i] = '0;
		end
		o_checked = 0;
		o_value_errors = 0;
		o_protocol_errors = 0;
	end

	// Lane picked by shifting the word down, then extended
	function automatic logic [31:0] load_lane(input logic [31:0] word, input logic [1:0] offset,
			input mem_width_e width, input logic is_signed);
		logic [31:0] lane;
		lane = word >> (8 * offset);
		case (width)
			MEM_BYTE: lane = (is_signed && lane[7]) ? (lane | 32'hffff_ff00) : (lane & 32'hff);
			MEM_HALF: lane = (is_signed && lane[15]) ? (lane | 32'hffff_0000) : (lane & 32'hffff);
			default: lane = word;
		endcase
		return lane;
	endfunction

	function automatic logic [31:0] merge_store(input logic [31:0] word, input logic [1:0] offset,
			input mem_width_e width, input logic [31:0] data);
		logic [31:0] mask;
		case (width)
			MEM_BYTE: mask = 32'h0000_00ff << (8 * offset);
			MEM_HALF: mask = 32'h0000_ffff << (8 * offset);
			default: mask = 32'hffff_ffff;
		endcase
		return (word & ~mask) | ((data << (8 * offset)) & mask);
	endfunction

	task automatic check_value(input string test, input string field, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			o_value_errors++;
			$display("FAILED %s.%s expected %h actual %h", test, field, expected, actual);
		end
	endtask

	task automatic complete_instruction();
		logic [RAM_ADDR_BITS-1:0] index;
		logic [31:0] expected_rd;
		string test;
		index = i_req.address[RAM_ADDR_BITS+1:2];
		expected_rd = last_rd;
		if (i_req.mem_read) begin
			test = "load";
		end else if (i_req.mem_write) begin
			test = "store";
		end else begin
			test = "pass_through";
		end
		if (i_req.mem_read) begin
			expected_rd = load_lane(mem_model[index], i_req.address[1:0], i_req.width,
				i_req.is_signed);
		end else if (i_req.mem_write) begin
			mem_model[index] = merge_store(mem_model[index], i_req.address[1:0], i_req.width,
				i_req.rd);
		end else begin
			expected_rd = i_req.rd;
			check_value(test, "latency", 32'd1, 32'(wait_cycles));
		end
		check_value(test, "rd", expected_rd, i_result.rd);
		check_value(test, "inst_rd", 32'(i_req.inst_rd), 32'(i_result.inst_rd));
		check_value(test, "pc_next", i_req.pc_next, i_result.pc_next);
		if (i_req.inst_rd != '0) begin
			reg_model[i_req.inst_rd] = expected_rd;
		end
		last_rd = expected_rd;
		o_checked++;
	endtask

	// Sampled on the falling edge, away from the driven rising edge
	always @(negedge i_clock) begin
		if (i_reset) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				reg_model[i] = '0;
			end
			last_rd = '0;
			last_req_tag = '0;
			pending = 1'b0;
			wait_cycles = 0;
		end else begin
			if (i_stall && (i_req.tag == i_result.tag)) begin
				o_protocol_errors++;
				$display("o_stall is high although request and result tags are both %0d",
					i_req.tag);
			end
			if (i_req.tag != last_req_tag) begin
				last_req_tag = i_req.tag;
				pending = 1'b1;
				wait_cycles = 0;
				if (i_stall != (i_req.mem_read | i_req.mem_write)) begin
					o_protocol_errors++;
					$display("o_stall was %0b on the first cycle of tag %0d", i_stall, i_req.tag);
				end
			end else if (pending) begin
				wait_cycles++;
				if (i_result.tag == i_req.tag) begin
					complete_instruction();
					pending = 1'b0;
				end else if (wait_cycles == ACCESS_BOUND) begin
					o_protocol_errors++;
					$display("Access with tag %0d did not finish within %0d cycles", i_req.tag,
						ACCESS_BOUND);
				end
			end
			if (i_sweep) begin
				check_value("regfile", $sformatf("x%0d", i_read_index), reg_model[i_read_index],
					i_read_data);
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_mem_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mem_subsystem
	import cpu_pkg::*;
();

	localparam int NUM_INSTR = 400;
	localparam int RESET_CYCLES = 8;
	localparam logic [31:0] SEED = 32'h6f547029;
	localparam int TIMEOUT_CYCLES =
		NUM_INSTR * (3 * RAM_WAIT + 8) + RESET_CYCLES + REG_COUNT + 8;

	logic clock;
	logic reset;
	mem_req_t req;
	logic stall;
	mem_result_t result;
	logic sweep;
	logic [REG_BITS-1:0] read_index;
	logic [31:0] read_data;
	logic [31:0] rng_state;
	int cycle_count;
	int checked;
	int value_errors;
	int protocol_errors;

	mem_subsystem mem_subsystem_i (
		.i_clock(clock),
		.i_reset(reset),
		.i_req(req),
		.o_stall(stall),
		.o_result(result),
		.i_read_index(read_index),
		.o_read_data(read_data)
	);

	tb_checker tb_checker_i (
		.i_clock(clock),
		.i_reset(reset),
		.i_req(req),
		.i_stall(stall),
		.i_result(result),
		.i_sweep(sweep),
		.i_read_index(read_index),
		.i_read_data(read_data),
		.o_checked(checked),
		.o_value_errors(value_errors),
		.o_protocol_errors(protocol_errors)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_random(output logic [31:0] value);
		rng_state = xorshift32(rng_state);
		value = rng_state;
	endtask

	// Ops 0-1 pass through, 2-4 load, 5-7 store; addresses in the first 64 words
	task automatic build_request(input logic [TAG_BITS-1:0] tag, output mem_req_t r);
		logic [31:0] pick;
		logic [31:0] data;
		r = '0;
		r.tag = tag;
		next_random(data);
		r.rd = data;
		next_random(data);
		r.pc_next = {data[31:2], 2'b00};
		next_random(pick);
		r.inst_rd = pick[4:0];
		r.mem_read = (pick[7:5] >= 3'd2) && (pick[7:5] <= 3'd4);
		r.mem_write = (pick[7:5] >= 3'd5);
		r.is_signed = pick[8];
		r.address = {24'd0, pick[17:12], 2'b00};
		case (pick[11:9] % 3)
			0: begin
				r.width = MEM_BYTE;
				r.address[1:0] = pick[19:18];
			end
			1: begin
				r.width = MEM_HALF;
				r.address[1] = pick[18];
			end
			default: begin
				r.width = MEM_WORD;
			end
		endcase
	endtask

	task automatic wait_for_finish(input logic [TAG_BITS-1:0] tag);
		@(negedge clock);
		while ((result.tag != tag) || stall) begin
			@(negedge clock);
		end
	endtask

	task automatic print_counts();
		$display("Checked %0d results: %0d value errors, %0d protocol errors",
			checked, value_errors, protocol_errors);
	endtask

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Simulation timed out after %0d cycles", cycle_count);
		print_counts();
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		mem_req_t next;
		rng_state = SEED;
		reset = 1'b1;
		req = '0;
		sweep = 1'b0;
		read_index = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		for (int n = 0; n < NUM_INSTR; n++) begin
			@(posedge clock);
			build_request(TAG_BITS'(n + 1), next);
			req <= next;
			wait_for_finish(next.tag);
		end
		// Last writeback lands one cycle after the final result
		repeat (2) @(posedge clock);
		for (int k = 0; k < REG_COUNT; k++) begin
			sweep <= 1'b1;
			read_index <= REG_BITS'(k);
			@(posedge clock);
		end
		sweep <= 1'b0;
		@(negedge clock);
		print_counts();
		if ((value_errors == 0) && (protocol_errors == 0) && (checked == NUM_INSTR)) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
cpu_pkg.sv
mem_lane_align.sv
cpu_memory.sv
bus_ram.sv
writeback_regfile.sv
mem_subsystem.sv
tb_checker.sv
tb_mem_subsystem.sv
